/* Makefile */
TOOL  := verilator
FLAGS := --binary -j 0
LINT  := --lint-only --timing
TOP   := tb_grid_arbiter
FLIST := list.f
PASS  := PASS: all tests

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS)"

clean:
	rm -rf obj_dir

/* include/arb_defs.svh */
// Grid arbiter dimensions
// Requester matrix size and the address widths derived from it
`ifndef ARB_DEFS_SVH
`define ARB_DEFS_SVH

// Number of requester rows
`define ARB_ROWS 4

// Requesters per row
`define ARB_COLS 4

// Row address width that covers ARB_ROWS
`define ARB_ROW_W 2

// Column address width that covers ARB_COLS
`define ARB_COL_W 2

`endif

/* list.f */
+incdir+include
rtl/arb_pkg.sv
rtl/priority_arb.sv
rtl/row_arbiter.sv
rtl/column_arbiter.sv
rtl/grid_arbiter.sv
test/grant_checker.sv
test/tb_grid_arbiter.sv

/* rtl/arb_pkg.sv */
// Grid arbiter types
// Request matrix, row selection state and grant record
`include "arb_defs.svh"

package arb_pkg;

    // One word per row, one bit per column
    typedef logic [`ARB_ROWS-1:0][`ARB_COLS-1:0] req_matrix_t;

    // Row stage state, handed to the column stage
    typedef struct packed
    {
        logic                  valid;  // A row is selected
        logic [`ARB_ROW_W-1:0] row;    // Selected row address
    } row_sel_t;

    // Grant strobe with its matrix address
    typedef struct packed
    {
        logic                  valid;  // Single-cycle strobe
        logic [`ARB_ROW_W-1:0] row;    // Granted row
        logic [`ARB_COL_W-1:0] col;    // Granted column
    } grant_t;

endpackage

/* rtl/column_arbiter.sv */
// Column stage of the grid arbiter
// Masked low-to-high column grants within the selected row
`include "arb_defs.svh"

module column_arbiter
(
    input  logic                 clk_i,
    input  logic                 reset_i,        // Async, active high
    input  logic                 enable_i,       // Low forces reset state
    input  arb_pkg::req_matrix_t req_i,          // Level requests
    input  arb_pkg::row_sel_t    row_sel_i,      // From the row stage
    output arb_pkg::grant_t      gnt_o,          // Registered grant strobe
    output logic                 grp_release_o   // One-cycle row done pulse
);

    logic [`ARB_COLS-1:0]  row_word;     // Requests of the selected row
    logic [`ARB_COLS-1:0]  mask_q;       // Columns still open this visit
    logic [`ARB_COLS-1:0]  mask_d;
    logic [`ARB_COLS-1:0]  masked_req;
    logic [`ARB_COLS-1:0]  col_gnt;      // One-hot winner
    logic [`ARB_COLS-1:0]  shift_mask;   // Columns above the winner
    logic [`ARB_COL_W-1:0] col_addr;
    logic                  row_busy;     // Selected row still requesting
    logic                  release_d;
    arb_pkg::grant_t       gnt_q;
    arb_pkg::grant_t       gnt_d;

    assign row_word   = req_i[row_sel_i.row];
    assign row_busy   = row_sel_i.valid && (|row_word);
    assign masked_req = row_word & mask_q;

    priority_arb #(.WIDTH(`ARB_COLS)) u_col_pick
    (
        .req_i (masked_req),
        .gnt_o (col_gnt)
    );

    // Encode winner and open only the columns above it
    always_comb
    begin
        col_addr   = '0;
        shift_mask = {`ARB_COLS{1'b1}};
        for (int c = 0; c < `ARB_COLS; c++)
        begin
            if (col_gnt[c])
            begin
                col_addr   = `ARB_COL_W'(c);
                shift_mask = {`ARB_COLS{1'b1}} << (c + 1);  // Zero after the top column
            end
        end
    end

    always_comb
    begin
        gnt_d       = '0;
        gnt_d.row   = row_sel_i.row;
        gnt_d.col   = col_addr;
        mask_d      = {`ARB_COLS{1'b1}};
        release_d   = 1'b0;
        if (grp_release_o)
        begin
            // No grant while the row stage moves on
        end
        else if (row_busy)
        begin
            if (|masked_req)
            begin
                gnt_d.valid = 1'b1;
                mask_d      = shift_mask;
            end
            else
                release_d = 1'b1;  // Row wants more but the mask is spent
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            gnt_q         <= '0;
            mask_q        <= {`ARB_COLS{1'b1}};
            grp_release_o <= 1'b0;
        end
        else if (!enable_i)
        begin
            gnt_q         <= '0;                 // No grants while disabled
            mask_q        <= {`ARB_COLS{1'b1}};
            grp_release_o <= 1'b0;
        end
        else
        begin
            gnt_q         <= gnt_d;
            mask_q        <= mask_d;
            grp_release_o <= release_d;
        end
    end

    assign gnt_o = gnt_q;

endmodule

/* rtl/grid_arbiter.sv */
// Two-level grid arbiter top
// Row stage picks a row, column stage grants its columns in turn
module grid_arbiter
(
    input  logic                 clk_i,
    input  logic                 reset_i,   // Async, active high
    input  logic                 enable_i,  // Global enable
    input  arb_pkg::req_matrix_t req_i,     // Level requests, one bit per requester
    output arb_pkg::grant_t      gnt_o      // Single-cycle grant strobe
);

    arb_pkg::row_sel_t row_sel;      // Row stage to column stage
    logic              grp_release;  // Column stage back to row stage

    row_arbiter u_row_arb
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (enable_i),
        .req_i         (req_i),
        .grp_release_i (grp_release),
        .row_sel_o     (row_sel)
    );

    column_arbiter u_col_arb
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (enable_i),
        .req_i         (req_i),
        .row_sel_i     (row_sel),
        .gnt_o         (gnt_o),
        .grp_release_o (grp_release)
    );

endmodule

/* rtl/priority_arb.sv */
// Fixed-priority picker
// One-hot grant of the lowest set request bit
module priority_arb
#(
    parameter int WIDTH = 4
)
(
    input  logic [WIDTH-1:0] req_i,  // Request vector
    output logic [WIDTH-1:0] gnt_o   // One-hot grant that is zero when idle
);

    logic [WIDTH-1:0] req_neg;  // Two's complement of the requests

    // Negation flips every bit above the lowest one
    assign req_neg = ~req_i + 1'b1;

    // Only the lowest set bit survives the AND
    assign gnt_o = req_i & req_neg;

endmodule

/* rtl/row_arbiter.sv */
// Row stage of the grid arbiter
// Round-robin pick of one requesting row that a group release moves on
`include "arb_defs.svh"

module row_arbiter
(
    input  logic               clk_i,
    input  logic               reset_i,          // Async, active high
    input  logic               enable_i,         // Low forces reset state
    input  arb_pkg::req_matrix_t req_i,          // Level requests
    input  logic               grp_release_i,    // Column stage finished this row
    output arb_pkg::row_sel_t  row_sel_o         // Registered selection
);

    logic [`ARB_ROWS-1:0]  row_req;      // Row has at least one request
    logic [`ARB_ROWS-1:0]  rr_mask_q;    // Rows after the last pick
    logic [`ARB_ROWS-1:0]  rr_mask_d;
    logic [`ARB_ROWS-1:0]  masked_req;   // Requesting rows under the mask
    logic [`ARB_ROWS-1:0]  masked_gnt;
    logic [`ARB_ROWS-1:0]  plain_gnt;    // Unmasked pick for wrap-around
    logic [`ARB_ROWS-1:0]  pick_gnt;     // Winning one-hot row
    logic [`ARB_ROW_W-1:0] pick_row;     // Encoded winner
    logic                  reselect;
    arb_pkg::row_sel_t     sel_q;
    arb_pkg::row_sel_t     sel_d;

    // OR-reduce each row word
    always_comb
    begin
        for (int r = 0; r < `ARB_ROWS; r++)
        begin
            row_req[r] = |req_i[r];
        end
    end

    assign masked_req = row_req & rr_mask_q;

    priority_arb #(.WIDTH(`ARB_ROWS)) u_masked_pick
    (
        .req_i (masked_req),
        .gnt_o (masked_gnt)
    );

    priority_arb #(.WIDTH(`ARB_ROWS)) u_plain_pick
    (
        .req_i (row_req),
        .gnt_o (plain_gnt)
    );

    // Masked pick wins and plain pick wraps back to the low rows
    assign pick_gnt = (|masked_req) ? masked_gnt : plain_gnt;

    // One-hot to row address
    always_comb
    begin
        pick_row = '0;
        for (int r = 0; r < `ARB_ROWS; r++)
        begin
            if (pick_gnt[r])
                pick_row = `ARB_ROW_W'(r);
        end
    end

    // No row yet, release from the column stage, or current row drained
    assign reselect = !sel_q.valid || grp_release_i || !row_req[sel_q.row];

    always_comb
    begin
        sel_d     = sel_q;
        rr_mask_d = rr_mask_q;
        if (reselect)
        begin
            if (|row_req)
            begin
                sel_d.valid = 1'b1;
                sel_d.row   = pick_row;
                rr_mask_d   = {`ARB_ROWS{1'b1}} << (pick_row + 1);  // Strictly above the pick
            end
            else
                sel_d.valid = 1'b0;  // Pointer holds while no row requests
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            sel_q     <= '0;
            rr_mask_q <= {`ARB_ROWS{1'b1}};
        end
        else if (!enable_i)
        begin
            sel_q     <= '0;                 // Same as reset while disabled
            rr_mask_q <= {`ARB_ROWS{1'b1}};
        end
        else
        begin
            sel_q     <= sel_d;
            rr_mask_q <= rr_mask_d;
        end
    end

    assign row_sel_o = sel_q;

endmodule

/* test/grant_checker.sv */
// Grant monitor for the grid arbiter
// Reference rules for grants, row moves and waiting time checked every cycle
`include "arb_defs.svh"

module grant_checker
(
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 enable_i,
    input  arb_pkg::req_matrix_t req_i,
    input  arb_pkg::grant_t      gnt_i,
    input  arb_pkg::row_sel_t    row_sel_i,     // Row stage state inside the DUT
    input  logic                 all_phase_i,   // Every requester holds its bit
    output int                   error_count_o,
    output int                   check_count_o
);

    localparam int N_REQ      = `ARB_ROWS * `ARB_COLS;
    localparam int WAIT_LIMIT = `ARB_ROWS * (`ARB_COLS + 2) + 2;
    localparam int SETTLE     = 8;                  // Grants left over from the last phase

    arb_pkg::req_matrix_t prev_req = '0;            // Requests seen by the last edge
    arb_pkg::row_sel_t    prev_sel = '0;
    arb_pkg::grant_t      prev_gnt = '0;
    arb_pkg::grant_t      last_gnt = '0;            // Last valid grant
    logic                 prev_en  = 1'b0;
    int                   errors   = 0;
    int                   checks   = 0;
    int                   all_grants = 0;
    int                   wait_cnt [N_REQ];

    assign error_count_o = errors;
    assign check_count_o = checks;

    // Next requesting row strictly after cur that wraps onto cur itself last
    function automatic int next_row(input int cur, input arb_pkg::req_matrix_t req);
        int r;
        int found;
        found = -1;
        for (int i = 1; i <= `ARB_ROWS; i++)
        begin
            r = (cur + i) % `ARB_ROWS;
            if (found < 0 && (|req[r]))
                found = r;
        end
        return found;
    endfunction

    task automatic log_error(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    // Outputs are settled mid-cycle
    always @(negedge clk_i)
    begin
        int idx;
        int exp_row;
        int exp_idx;
        idx = int'(gnt_i.row) * `ARB_COLS + int'(gnt_i.col);
        checks++;
        if (reset_i || !prev_en)
        begin
            if (gnt_i.valid)
                log_error("grant while in reset or disabled");
            for (int i = 0; i < N_REQ; i++)
                wait_cnt[i] = 0;
        end
        else
        begin
            if (gnt_i.valid)
            begin
                if (!prev_req[gnt_i.row][gnt_i.col])
                    log_error($sformatf("grant r%0d c%0d without a request",
                                        gnt_i.row, gnt_i.col));
                // Back-to-back grants in one row climb the columns
                if (prev_gnt.valid && prev_gnt.row == gnt_i.row && gnt_i.col <= prev_gnt.col)
                    log_error($sformatf("column c%0d after c%0d in row r%0d",
                                        gnt_i.col, prev_gnt.col, gnt_i.row));
                if (all_phase_i)
                begin
                    exp_idx = (int'(last_gnt.row) * `ARB_COLS + int'(last_gnt.col) + 1) % N_REQ;
                    if (all_grants >= SETTLE && idx != exp_idx)
                        log_error($sformatf("grant %0d in full load, expected %0d",
                                            idx, exp_idx));
                    all_grants++;
                end
                last_gnt = gnt_i;
            end
            if (prev_sel.valid && row_sel_i.valid && row_sel_i.row != prev_sel.row)
            begin
                exp_row = next_row(int'(prev_sel.row), prev_req);
                if (exp_row != int'(row_sel_i.row))
                    log_error($sformatf("row moved r%0d to r%0d, expected r%0d",
                                        prev_sel.row, row_sel_i.row, exp_row));
            end
            for (int i = 0; i < N_REQ; i++)
            begin
                if (gnt_i.valid && idx == i)
                    wait_cnt[i] = 0;
                else if (prev_req[i / `ARB_COLS][i % `ARB_COLS])
                begin
                    wait_cnt[i]++;
                    if (wait_cnt[i] > WAIT_LIMIT)
                    begin
                        $display("requester r%0d c%0d starved for more than %0d cycles at %0t",
                                 i / `ARB_COLS, i % `ARB_COLS, WAIT_LIMIT, $time);
                        errors++;
                        wait_cnt[i] = 0;
                    end
                end
                else
                    wait_cnt[i] = 0;
            end
        end
        if (!all_phase_i)
            all_grants = 0;
        prev_req = req_i;
        prev_en  = enable_i && !reset_i;
        prev_sel = row_sel_i;
        prev_gnt = gnt_i;
    end

endmodule

/* test/tb_grid_arbiter.sv */
// Testbench for the grid arbiter
// Random requesters from an LFSR, enable toggling, watchdog and final report
`include "arb_defs.svh"

module tb_grid_arbiter;

    localparam int SPARSE_CYC = 300;
    localparam int DENSE_CYC  = 300;
    localparam int ALL_CYC    = 200;
    localparam int TOGGLE_CYC = 300;
    localparam int TOTAL_CYC  = SPARSE_CYC + DENSE_CYC + ALL_CYC + TOGGLE_CYC + 8;
    localparam int WATCHDOG   = (TOTAL_CYC + 100) * 40;  // Margin of 100 cycles

    logic                 clk_i;
    logic                 reset_i;
    logic                 enable_i;
    arb_pkg::req_matrix_t req_i;
    arb_pkg::grant_t      gnt_o;
    logic                 all_phase;
    logic [31:0]          lfsr_q;
    int                   error_count;
    int                   check_count;

    always #20 clk_i = ~clk_i;

    grid_arbiter dut0
    (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .enable_i (enable_i),
        .req_i    (req_i),
        .gnt_o    (gnt_o)
    );

    grant_checker chk0
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (enable_i),
        .req_i         (req_i),
        .gnt_i         (gnt_o),
        .row_sel_i     (dut0.row_sel),
        .all_phase_i   (all_phase),
        .error_count_o (error_count),
        .check_count_o (check_count)
    );

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic out;
        out = s[0];
        s   = s >> 1;
        if (out)
            s = s ^ 32'h8020_0003;
        return s;
    endfunction

    // True with odds of one in 2**nbits
    task automatic chance(input int nbits, output logic hit);
        hit = 1'b1;
        for (int i = 0; i < nbits; i++)
        begin
            hit    = hit & lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // One cycle of every requester model plus the enable line
    task automatic drive_cycle(input int set_bits, input logic toggle_en);
        logic hit;
        @(posedge clk_i);
        #2;
        for (int r = 0; r < `ARB_ROWS; r++)
        begin
            for (int c = 0; c < `ARB_COLS; c++)
            begin
                if (req_i[r][c])
                begin
                    if (gnt_o.valid && int'(gnt_o.row) == r && int'(gnt_o.col) == c)
                        req_i[r][c] = 1'b0;  // Served requester drops its bit
                end
                else
                begin
                    chance(set_bits, hit);
                    if (hit)
                        req_i[r][c] = 1'b1;
                end
            end
        end
        if (toggle_en)
        begin
            chance(2, hit);
            enable_i = !hit;  // Low about one cycle in four
        end
        else
            enable_i = 1'b1;
    endtask

    task automatic run_test(input string name, input int cycles, input int set_bits,
                            input logic toggle_en);
        int errors_before;
        errors_before = error_count;
        repeat (cycles) drive_cycle(set_bits, toggle_en);
        $display("test %s: %0d cycles, %0d errors", name, cycles, error_count - errors_before);
    endtask

    initial
    begin
        #(WATCHDOG);
        $display("timeout: the tests did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        clk_i     = 1'b0;
        reset_i   = 1'b1;
        enable_i  = 1'b0;
        req_i     = '0;
        all_phase = 1'b0;
        lfsr_q    = 32'h4852;
        repeat (2) @(posedge clk_i);
        #2;
        reset_i  = 1'b0;
        enable_i = 1'b1;
        run_test("sparse", SPARSE_CYC, 3, 1'b0);
        run_test("dense", DENSE_CYC, 1, 1'b0);
        all_phase = 1'b1;
        run_test("all requesting", ALL_CYC, 0, 1'b0);
        all_phase = 1'b0;
        run_test("enable toggle", TOGGLE_CYC, 1, 1'b1);
        repeat (4) @(posedge clk_i);
        $display("tests 4, checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule
